// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

    // address and data widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int be_w = data_w / 8;

    // direct-mapped, one word per set
    localparam int sets = 64;
    localparam int index_w = $clog2(sets);
    // address bits 31:8, above the index and byte offset
    localparam int tag_w = addr_w - index_w - 2;
    // valid bit on top of the tag
    localparam int tag_entry_w = tag_w + 1;

    // read value of an sram that is not enabled
    localparam logic [31:0] sram_poison = 32'hbad0bad0;

    // processor side request, held until done
    typedef struct packed {
        logic              ren;
        logic              wen;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [be_w-1:0]   byte_en;
    } cpu_req_t;

    // done is a single cycle pulse
    typedef struct packed {
        logic              done;
        logic [data_w-1:0] rdata;
    } cpu_rsp_t;

    // memory side uses the same shape
    typedef cpu_req_t mem_req_t;
    typedef cpu_rsp_t mem_rsp_t;

    typedef enum logic [1:0] {
        clear,
        idle,
        fill,
        write_thru
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: sram.sv
`timescale 1ns/1ps
`default_nettype none

module sram #(
    parameter int word_w = 32,
    parameter int depth = 64
) (
    input  logic                     CLK,
    input  logic [word_w-1:0]        wval,
    output logic [word_w-1:0]        rval,
    input  logic                     ren,
    input  logic                     wen,
    input  logic [$clog2(depth)-1:0] sel,
    input  logic [word_w-1:0]        wmask
);

    // storage array
    logic [word_w-1:0] mem [depth];

    // combinational read port
    always_comb begin
        if (ren) begin
            rval = mem[sel];
        end else begin
            // poison so a read without ren stands out
            rval = word_w'(cache_pkg::sram_poison);
        end
    end

    // masked write
    // mask bit set keeps the stored bit
    always_ff @(posedge CLK) begin
        if (wen) begin
            mem[sel] <= (wval & ~wmask) | (mem[sel] & wmask);
        end
    end

    // select must stay inside the array on writes
    a_sel_range: assert property (
        @(posedge CLK) wen |-> (int'(sel) < depth)
    ) else $error("sram write index %0d out of range", sel);

endmodule

`default_nettype wire

// File: cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  logic                               CLK,
    input  logic                               reset,
    input  cache_pkg::cpu_req_t                cpu_req,
    output cache_pkg::cpu_rsp_t                cpu_rsp,
    output cache_pkg::mem_req_t                mem_req,
    input  cache_pkg::mem_rsp_t                mem_rsp,
    output logic [cache_pkg::index_w-1:0]      tag_sel,
    output logic                               tag_ren,
    output logic                               tag_wen,
    output logic [cache_pkg::tag_entry_w-1:0]  tag_wval,
    input  logic [cache_pkg::tag_entry_w-1:0]  tag_rval,
    output logic [cache_pkg::index_w-1:0]      data_sel,
    output logic                               data_ren,
    output logic                               data_wen,
    output logic [cache_pkg::data_w-1:0]       data_wval,
    output logic [cache_pkg::data_w-1:0]       data_wmask,
    input  logic [cache_pkg::data_w-1:0]       data_rval
);

    cache_pkg::ctrl_state_t state;
    cache_pkg::ctrl_state_t next_state;
    // set being cleared during the sweep
    logic [cache_pkg::index_w-1:0] sweep_cnt;
    logic sweep_last;

    // address split
    logic [cache_pkg::index_w-1:0] req_index;
    logic [cache_pkg::tag_w-1:0]   req_tag;
    logic hit;
    // inverted byte enables, one bit per data bit
    logic [cache_pkg::data_w-1:0] byte_keep;

    // word aligned, bits 1:0 are byte offset
    assign req_index = cpu_req.addr[2 +: cache_pkg::index_w];
    assign req_tag = cpu_req.addr[cache_pkg::addr_w-1 -: cache_pkg::tag_w];

    // valid on top, then tag
    assign hit = tag_rval[cache_pkg::tag_entry_w-1]
        && (tag_rval[cache_pkg::tag_w-1:0] == req_tag);

    assign sweep_last = (sweep_cnt == cache_pkg::index_w'(cache_pkg::sets - 1));

    always_comb begin
        for (int i = 0; i < cache_pkg::be_w; i++) begin
            byte_keep[8*i +: 8] = {8{~cpu_req.byte_en[i]}};
        end
    end

    // state and sweep counter
    always_ff @(posedge CLK) begin
        if (reset) begin
            state <= cache_pkg::clear;
            sweep_cnt <= '0;
        end else begin
            state <= next_state;
            if (state == cache_pkg::clear) begin
                sweep_cnt <= sweep_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;

        // request fields pass straight to memory, strobes gated by state
        mem_req = cpu_req;
        mem_req.ren = 1'b0;
        mem_req.wen = 1'b0;

        cpu_rsp.done = 1'b0;
        cpu_rsp.rdata = data_rval;

        // tag lookup for the held request
        tag_sel = req_index;
        tag_ren = (state != cache_pkg::clear);
        tag_wen = 1'b0;
        tag_wval = {1'b1, req_tag};

        data_sel = req_index;
        data_ren = 1'b0;
        data_wen = 1'b0;
        data_wval = cpu_req.wdata;
        data_wmask = byte_keep;

        case (state)
            cache_pkg::clear: begin
                // zero entry, one set per cycle
                tag_sel = sweep_cnt;
                tag_wen = 1'b1;
                tag_wval = '0;
                if (sweep_last) begin
                    next_state = cache_pkg::idle;
                end
            end

            cache_pkg::idle: begin
                data_ren = cpu_req.ren;
                if (cpu_req.ren) begin
                    // hit answers in this cycle
                    if (hit) begin
                        cpu_rsp.done = 1'b1;
                    end else begin
                        next_state = cache_pkg::fill;
                    end
                end else if (cpu_req.wen) begin
                    next_state = cache_pkg::write_thru;
                end
            end

            cache_pkg::fill: begin
                mem_req.ren = 1'b1;
                if (mem_rsp.done) begin
                    // forward memory word and install line
                    cpu_rsp.done = 1'b1;
                    cpu_rsp.rdata = mem_rsp.rdata;
                    data_wen = 1'b1;
                    data_wval = mem_rsp.rdata;
                    data_wmask = '0;
                    tag_wen = 1'b1;
                    next_state = cache_pkg::idle;
                end
            end

            cache_pkg::write_thru: begin
                mem_req.wen = 1'b1;
                if (mem_rsp.done) begin
                    cpu_rsp.done = 1'b1;
                    // update cached copy only on a hit, no allocate
                    data_wen = hit;
                    next_state = cache_pkg::idle;
                end
            end

            default: begin
                next_state = cache_pkg::clear;
            end
        endcase
    end

    // requester issues one kind of access at a time
    a_cpu_one_strobe: assert property (
        @(posedge CLK) disable iff (reset) !(cpu_req.ren && cpu_req.wen)
    ) else $error("cpu request has ren and wen together");

    a_mem_one_strobe: assert property (
        @(posedge CLK) disable iff (reset) !(mem_req.ren && mem_req.wen)
    ) else $error("memory request has ren and wen together");

    // no response while the tag store is being cleared
    a_no_done_in_clear: assert property (
        @(posedge CLK) (state == cache_pkg::clear) |-> !cpu_rsp.done
    ) else $error("cpu done during tag clear");

endmodule

`default_nettype wire

// File: l1_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l1_cache (
    input  logic                CLK,
    input  logic                reset,
    input  cache_pkg::cpu_req_t cpu_req,
    output cache_pkg::cpu_rsp_t cpu_rsp,
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp
);

    // tag store port
    logic [cache_pkg::index_w-1:0]     tag_sel;
    logic                              tag_ren;
    logic                              tag_wen;
    logic [cache_pkg::tag_entry_w-1:0] tag_wval;
    logic [cache_pkg::tag_entry_w-1:0] tag_rval;

    // data store port
    logic [cache_pkg::index_w-1:0] data_sel;
    logic                          data_ren;
    logic                          data_wen;
    logic [cache_pkg::data_w-1:0]  data_wval;
    logic [cache_pkg::data_w-1:0]  data_wmask;
    logic [cache_pkg::data_w-1:0]  data_rval;

    cache_ctrl u_ctrl (
        .CLK        (CLK),
        .reset      (reset),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .tag_sel    (tag_sel),
        .tag_ren    (tag_ren),
        .tag_wen    (tag_wen),
        .tag_wval   (tag_wval),
        .tag_rval   (tag_rval),
        .data_sel   (data_sel),
        .data_ren   (data_ren),
        .data_wen   (data_wen),
        .data_wval  (data_wval),
        .data_wmask (data_wmask),
        .data_rval  (data_rval)
    );

    // valid plus tag per set
    // whole entry written every time, so no mask bits set
    sram #(
        .word_w (cache_pkg::tag_entry_w),
        .depth  (cache_pkg::sets)
    ) u_tag_store (
        .CLK   (CLK),
        .wval  (tag_wval),
        .rval  (tag_rval),
        .ren   (tag_ren),
        .wen   (tag_wen),
        .sel   (tag_sel),
        .wmask ('0)
    );

    // one word per set, byte masked writes
    sram #(
        .word_w (cache_pkg::data_w),
        .depth  (cache_pkg::sets)
    ) u_data_store (
        .CLK   (CLK),
        .wval  (data_wval),
        .rval  (data_rval),
        .ren   (data_ren),
        .wen   (data_wen),
        .sel   (data_sel),
        .wmask (data_wmask)
    );

endmodule

`default_nettype wire

// File: cache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cache_checker #(
    parameter logic [31:0] fill_key = 32'h0
) (
    input  logic                CLK,
    input  logic                reset,
    input  cache_pkg::cpu_req_t cpu_req,
    input  cache_pkg::cpu_rsp_t cpu_rsp,
    input  cache_pkg::mem_req_t mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp,
    output int                  test_count,
    output int                  error_count
);

    // written words by word address, the rest follow the fill pattern
    logic [31:0] ref_mem [logic [29:0]];
    // expected cache contents, valid plus tag per set
    logic                        tag_valid [cache_pkg::sets];
    logic [cache_pkg::tag_w-1:0] tag_model [cache_pkg::sets];
    // request in flight
    cache_pkg::cpu_req_t cur;
    logic active = 1'b0;
    logic model_hit;
    int sweep_left = 0;
    int mem_reads;
    int mem_writes;
    int cycles;
    int op_errors;
    int tests = 0;
    int errors = 0;

    assign test_count = tests;
    assign error_count = errors;

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        if (ref_mem.exists(addr[31:2])) begin
            return ref_mem[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ fill_key;
    endfunction

    task automatic value_error(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        $display("ERROR %s expected %h actual %h", name, exp, act);
        op_errors++;
        errors++;
    endtask

    task automatic fault(input string what);
        $display("%s", what);
        op_errors++;
        errors++;
    endtask

    task automatic start_op();
        logic [cache_pkg::index_w-1:0] idx;
        idx = cpu_req.addr[2 +: cache_pkg::index_w];
        cur = cpu_req;
        active = 1'b1;
        // hit only when the set holds this tag
        model_hit = tag_valid[idx]
            && (tag_model[idx] == cpu_req.addr[cache_pkg::addr_w-1 -: cache_pkg::tag_w]);
        mem_reads = 0;
        mem_writes = 0;
        cycles = 0;
        op_errors = 0;
    endtask

    task automatic finish_op();
        logic [cache_pkg::index_w-1:0] idx;
        logic [31:0] expect_word;
        idx = cur.addr[2 +: cache_pkg::index_w];
        expect_word = ref_word(cur.addr);
        if (cur.ren) begin
            if (cpu_rsp.rdata !== expect_word) begin
                value_error("rdata", expect_word, cpu_rsp.rdata);
            end
            // hit answers in the request cycle with no memory traffic
            if (model_hit && (mem_reads != 0 || cycles != 0)) begin
                fault($sformatf("read of %h should hit but took %0d cycles", cur.addr, cycles));
            end
            if (!model_hit && mem_reads != 1) begin
                fault($sformatf("read miss of %h made %0d memory reads", cur.addr, mem_reads));
            end
            // line filled or refreshed
            tag_valid[idx] = 1'b1;
            tag_model[idx] = cur.addr[cache_pkg::addr_w-1 -: cache_pkg::tag_w];
        end else begin
            if (mem_writes != 1 || mem_reads != 0) begin
                fault($sformatf("write of %h made %0d memory writes", cur.addr, mem_writes));
            end
            // byte merge, tag model untouched since there is no allocate
            for (int b = 0; b < 4; b++) begin
                if (cur.byte_en[b]) begin
                    expect_word[8*b +: 8] = cur.wdata[8*b +: 8];
                end
            end
            ref_mem[cur.addr[31:2]] = expect_word;
        end
        tests++;
        $display("test %0d %s %h %s: %s", tests, cur.ren ? "read " : "write", cur.addr,
                 model_hit ? "hit " : "miss", op_errors == 0 ? "ok" : "FAIL");
        active = 1'b0;
    endtask

    always @(posedge CLK) begin
        if (reset || sweep_left > 0) begin
            if (reset) begin
                sweep_left = cache_pkg::sets;
                active = 1'b0;
                op_errors = 0;
                for (int i = 0; i < cache_pkg::sets; i++) begin
                    tag_valid[i] = 1'b0;
                end
            end else begin
                sweep_left--;
            end
            // tag clear running, both ports quiet
            if (cpu_rsp.done === 1'b1 || mem_req.ren === 1'b1 || mem_req.wen === 1'b1) begin
                fault("cache answered or used memory during the reset sweep");
            end
            if (!reset && sweep_left == 0) begin
                tests++;
                $display("test %0d reset sweep: %s", tests, op_errors == 0 ? "ok" : "FAIL");
            end
        end else begin
            if (!active && (cpu_req.ren || cpu_req.wen)) begin
                start_op();
            end
            if (active) begin
                // request fields must reach memory unchanged
                if ((mem_req.ren || mem_req.wen) && mem_req.addr !== cur.addr) begin
                    value_error("mem_req.addr", cur.addr, mem_req.addr);
                end
                if (mem_req.wen && mem_req.wdata !== cur.wdata) begin
                    value_error("mem_req.wdata", cur.wdata, mem_req.wdata);
                end
                if (mem_req.wen && mem_req.byte_en !== cur.byte_en) begin
                    value_error("mem_req.byte_en", 32'(cur.byte_en), 32'(mem_req.byte_en));
                end
                if (mem_rsp.done) begin
                    mem_reads += int'(mem_req.ren);
                    mem_writes += int'(mem_req.wen);
                end
                if (cpu_rsp.done) begin
                    finish_op();
                end else begin
                    cycles++;
                end
            end else if (cpu_rsp.done || mem_req.ren || mem_req.wen) begin
                fault("cache bus activity with no request pending");
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache;

    localparam int clk_period = 40;
    localparam int n_random = 300;
    localparam int n_directed = 6;
    localparam int n_ops = n_directed + n_random;
    // reset sweep is reported as one more test
    localparam int n_tests = n_ops + 1;
    localparam logic [31:0] fill_key = 32'h5ac3_3ca5;

    logic CLK;
    logic reset;
    cache_pkg::cpu_req_t cpu_req;
    cache_pkg::cpu_rsp_t cpu_rsp;
    cache_pkg::mem_req_t mem_req;
    cache_pkg::mem_rsp_t mem_rsp;
    int test_count;
    int error_count;
    logic done_seen;
    logic [31:0] stim_rng;
    logic [31:0] lat_rng;
    // backing memory, word address keyed
    logic [31:0] mem_words [logic [29:0]];

    l1_cache u_dut (
        .CLK     (CLK),
        .reset   (reset),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    cache_checker #(.fill_key(fill_key)) u_checker (
        .CLK         (CLK),
        .reset       (reset),
        .cpu_req     (cpu_req),
        .cpu_rsp     (cpu_rsp),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .test_count  (test_count),
        .error_count (error_count)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // few tags per index so hits and conflicts both show up
    function automatic logic [31:0] pick_addr(input logic [31:0] r);
        logic [23:0] tag;
        tag = 24'h00a100 + 24'(r[25:24]) * 24'h010203;
        return {tag, 2'b00, r[19:16], 2'b00};
    endfunction

    initial begin
        CLK = 1'b0;
        forever #(clk_period / 2) CLK = ~CLK;
    end

    // done as seen at the edge, read back on the falling edge
    always @(posedge CLK) begin
        done_seen <= cpu_rsp.done;
    end

    task automatic run_op(input logic is_write, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] be);
        cpu_req.ren = !is_write;
        cpu_req.wen = is_write;
        cpu_req.addr = addr;
        cpu_req.wdata = wdata;
        cpu_req.byte_en = be;
        @(negedge CLK);
        while (!done_seen) begin
            @(negedge CLK);
        end
    endtask

    // memory model with random latency, 1 to 8 cycles
    initial begin : mem_responder
        int wait_cnt;
        logic [31:0] word;
        wait_cnt = 0;
        mem_rsp = '0;
        lat_rng = lcg_step(32'h722f);
        forever begin
            @(negedge CLK);
            if (mem_rsp.done) begin
                mem_rsp.done = 1'b0;
            end else if (mem_req.ren || mem_req.wen) begin
                if (wait_cnt == 0) begin
                    lat_rng = lcg_step(lat_rng);
                    wait_cnt = 1 + int'(lat_rng[18:16]);
                end
                wait_cnt--;
                if (wait_cnt == 0) begin
                    word = {mem_req.addr[31:2], 2'b00} ^ fill_key;
                    if (mem_words.exists(mem_req.addr[31:2])) begin
                        word = mem_words[mem_req.addr[31:2]];
                    end
                    if (mem_req.wen) begin
                        for (int b = 0; b < 4; b++) begin
                            if (mem_req.byte_en[b]) begin
                                word[8*b +: 8] = mem_req.wdata[8*b +: 8];
                            end
                        end
                        mem_words[mem_req.addr[31:2]] = word;
                    end
                    mem_rsp.rdata = word;
                    mem_rsp.done = 1'b1;
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] addr_a;
        logic [31:0] addr_b;
        logic [31:0] r;
        reset = 1'b1;
        cpu_req = '0;
        stim_rng = 32'h722f;
        // same index 40, different tags, outside the random pool
        addr_a = {24'h00a100, 6'd40, 2'b00};
        addr_b = {24'h0bb200, 6'd40, 2'b00};
        repeat (8) @(negedge CLK);
        reset = 1'b0;
        // one set cleared per cycle
        repeat (cache_pkg::sets) @(negedge CLK);

        run_op(1'b0, addr_a, 32'h0, 4'h0);
        // partial write to a cached word, then read the merge back
        run_op(1'b1, addr_a, 32'hdead_beef, 4'b0101);
        run_op(1'b0, addr_a, 32'h0, 4'h0);
        // write miss must not allocate
        run_op(1'b1, addr_b, 32'h1234_5678, 4'hf);
        run_op(1'b0, addr_b, 32'h0, 4'h0);
        // a was evicted by b
        run_op(1'b0, addr_a, 32'h0, 4'h0);

        for (int i = 0; i < n_random; i++) begin
            stim_rng = lcg_step(stim_rng);
            r = stim_rng;
            stim_rng = lcg_step(stim_rng);
            // about three writes in eight
            run_op(r[31:29] < 3'd3, pick_addr(r), stim_rng, r[23:20]);
        end
        cpu_req = '0;
        repeat (4) @(negedge CLK);

        $display("%0d of %0d tests run, %0d errors", test_count, n_tests, error_count);
        if (test_count != n_tests) begin
            $display("not every request was answered");
        end
        if (error_count == 0 && test_count == n_tests) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // worst case per op is 8 memory cycles plus a few of overhead
    initial begin : watchdog
        repeat (n_ops * (8 + 4) + 200) @(posedge CLK);
        $display("timeout, the cache stopped answering requests");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
cache_pkg.sv
sram.sv
cache_ctrl.sv
l1_cache.sv
cache_checker.sv
tb_cache.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_cache
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
